/* all.f */
logic/cardPkg.sv
logic/handPkg.sv
logic/rankMatchCounter.sv
logic/straightDetector.sv
logic/handRanker.sv
logic/pokerHand.sv
testbench/tbClock.sv
testbench/pokerHandTb.sv

/* testbench/pokerHandTb.sv */
`timescale 1ns/10ps
`default_nettype none

module pokerHandTb;

	import cardPkg::*;
	import handPkg::*;

	localparam int resetCycles = 10;
	localparam int streamHands = 400;
	// tests need roughly 480 cycles
	// limit is about four times that
	localparam int timeoutCycles = 2000;

	logic clk;
	logic arstN;
	cardT card0;
	cardT card1;
	cardT card2;
	cardT card3;
	cardT card4;
	handTypeT handType;

	int errorCount;
	int cycleCount = 0;
	logic [31:0] lcgState;

	tbClock clockGen (
		.clk(clk)
	);

	pokerHand dut (
		.clk(clk),
		.arstN(arstN),
		.card0(card0),
		.card1(card1),
		.card2(card2),
		.card3(card3),
		.card4(card4),
		.handType(handType)
	);

	// 32-bit LCG
	// upper bits are the useful ones
	function automatic logic [31:0] nextRandom();
		lcgState = lcgState * 32'd1664525 + 32'd1013904223;
		return lcgState;
	endfunction

	function automatic cardT makeCard(input suitT s, input rankT r);
		return {s, r};
	endfunction

	// cards as hex with the suit digit before the rank digit
	function automatic string handText(input cardT h0, h1, h2, h3, h4);
		return $sformatf("%h %h %h %h %h", h0, h1, h2, h3, h4);
	endfunction

	// expected type from a rank histogram, min/max run test and flush priority
	function automatic handTypeT referenceType(input cardT h0, h1, h2, h3, h4);
		cardT h [5];
		int hist [16];
		int pairs;
		int trips;
		int quads;
		logic sameSuit;
		logic isRun;
		logic aceHigh;
		rankT lo;
		rankT hi;
		h = '{h0, h1, h2, h3, h4};
		foreach (hist[v]) hist[v] = 0;
		foreach (h[i]) hist[h[i][3:0]]++;
		pairs = 0;
		trips = 0;
		quads = 0;
		foreach (hist[v]) begin
			if (hist[v] == 2) pairs++;
			else if (hist[v] == 3) trips++;
			else if (hist[v] >= 4) quads++;
		end
		sameSuit = 1'b1;
		lo = h[0][3:0];
		hi = h[0][3:0];
		foreach (h[i]) begin
			if (h[i][5:4] != h[0][5:4]) sameSuit = 1'b0;
			if (h[i][3:0] < lo) lo = h[i][3:0];
			if (h[i][3:0] > hi) hi = h[i][3:0];
		end
		// ace plus every rank from ten to king
		aceHigh = (hist[aceRank] == 1);
		for (int v = tenRank; v <= kingRank; v++) begin
			if (hist[v] != 1) aceHigh = 1'b0;
		end
		isRun = (pairs + trips + quads == 0) && ((hi - lo == 4) || aceHigh);
		if (sameSuit && isRun) return straightFlush;
		if (sameSuit) return flush;
		if (isRun) return straight;
		if (quads > 0) return fourOfAKind;
		if (trips > 0 && pairs > 0) return fullHouse;
		if (trips > 0) return threeOfAKind;
		if (pairs == 2) return twoPairs;
		if (pairs == 1) return onePair;
		return highCard;
	endfunction

	task automatic driveHand(input cardT h0, h1, h2, h3, h4);
		card0 = h0;
		card1 = h1;
		card2 = h2;
		card3 = h3;
		card4 = h4;
	endtask

	task automatic checkType(input string what, input handTypeT expected);
		if (handType !== expected) begin
			errorCount++;
			$display("FAILED at %0d ns: %s, expected type %0d, got %0d",
				$time, what, expected, handType);
		end
	endtask

	// one hand in and its result two rising edges later
	task automatic applyHand(input string label, input cardT h0, h1, h2, h3, h4,
		input handTypeT expected);
		string text;
		text = $sformatf("%s [%s]", label, handText(h0, h1, h2, h3, h4));
		if (referenceType(h0, h1, h2, h3, h4) != expected) begin
			errorCount++;
			$display("reference model disagrees with the directed value for %s", text);
		end
		@(negedge clk);
		driveHand(h0, h1, h2, h3, h4);
		@(posedge clk);
		@(posedge clk);
		@(negedge clk);
		checkType(text, expected);
	endtask

	// a flush hand sits on the inputs so a leak past reset would show
	task automatic testReset();
		arstN = 1'b0;
		driveHand(makeCard(1, 2), makeCard(1, 5), makeCard(1, 8), makeCard(1, 11),
			makeCard(1, 13));
		repeat (resetCycles) begin
			@(negedge clk);
			checkType("during reset", highCard);
		end
		arstN = 1'b1;
		@(posedge clk);
		@(negedge clk);
		checkType("first hand still in the input stage", highCard);
		@(posedge clk);
		@(negedge clk);
		checkType("first hand after both stages", flush);
	endtask

	task automatic testEachType();
		applyHand("high card", makeCard(0, 2), makeCard(1, 5), makeCard(2, 9),
			makeCard(3, 11), makeCard(0, 13), highCard);
		applyHand("one pair", makeCard(0, 3), makeCard(1, 3), makeCard(2, 7),
			makeCard(3, 9), makeCard(0, 12), onePair);
		applyHand("two pairs", makeCard(0, 4), makeCard(1, 4), makeCard(2, 8),
			makeCard(3, 8), makeCard(0, 13), twoPairs);
		applyHand("three of a kind", makeCard(0, 6), makeCard(1, 6), makeCard(2, 6),
			makeCard(3, 2), makeCard(0, 11), threeOfAKind);
		applyHand("straight", makeCard(0, 7), makeCard(1, 5), makeCard(2, 9),
			makeCard(3, 6), makeCard(0, 8), straight);
		applyHand("flush", makeCard(2, 2), makeCard(2, 6), makeCard(2, 9),
			makeCard(2, 11), makeCard(2, 13), flush);
		applyHand("full house", makeCard(0, 10), makeCard(1, 4), makeCard(2, 10),
			makeCard(3, 10), makeCard(0, 4), fullHouse);
		applyHand("four of a kind", makeCard(0, 7), makeCard(1, 7), makeCard(2, 2),
			makeCard(3, 7), makeCard(2, 7), fourOfAKind);
		applyHand("straight flush", makeCard(1, 3), makeCard(1, 4), makeCard(1, 5),
			makeCard(1, 6), makeCard(1, 7), straightFlush);
	endtask

	// ace low and ace high runs, then the wrap case
	// jack to ace plus a second ace passes the ace-high test but holds a pair
	task automatic testStraightEdges();
		applyHand("ace to five", makeCard(0, 1), makeCard(1, 2), makeCard(2, 3),
			makeCard(3, 4), makeCard(0, 5), straight);
		applyHand("ten to ace", makeCard(0, 10), makeCard(1, 11), makeCard(2, 12),
			makeCard(3, 13), makeCard(0, 1), straight);
		applyHand("jack to two wrap", makeCard(0, 11), makeCard(1, 12), makeCard(2, 13),
			makeCard(3, 1), makeCard(0, 2), highCard);
		applyHand("jack to ace with pair", makeCard(0, 11), makeCard(1, 12), makeCard(2, 13),
			makeCard(3, 1), makeCard(0, 1), onePair);
	endtask

	task automatic testPriority();
		applyHand("five alike", makeCard(0, 9), makeCard(1, 9), makeCard(2, 9),
			makeCard(3, 9), makeCard(0, 9), fourOfAKind);
		applyHand("flush with pair", makeCard(3, 8), makeCard(3, 8), makeCard(3, 3),
			makeCard(3, 5), makeCard(3, 13), flush);
		applyHand("suited ace high", makeCard(2, 1), makeCard(2, 13), makeCard(2, 12),
			makeCard(2, 11), makeCard(2, 10), straightFlush);
		applyHand("kings full", makeCard(0, 13), makeCard(1, 13), makeCard(2, 12),
			makeCard(3, 12), makeCard(1, 13), fullHouse);
	endtask

	// back to back hands with each result checked two edges after its drive
	task automatic testStreaming();
		handTypeT expectQ [$];
		string textQ [$];
		cardT h [5];
		logic [31:0] r;
		logic sameSuit;
		suitT baseSuit;
		logic runMode;
		int runStart;
		for (int i = 0; i < streamHands + 2; i++) begin
			@(negedge clk);
			if (i >= 2) begin
				checkType(textQ.pop_front(), expectQ.pop_front());
			end
			if (i < streamHands) begin
				r = nextRandom();
				// a quarter suited and an eighth forced into a run
				sameSuit = (r[31:30] == 2'b00);
				baseSuit = r[29:28];
				runMode = (r[27:25] == 3'b000);
				runStart = 1 + (r[23:16] % 10);
				for (int k = 0; k < cardsPerHand; k++) begin
					r = nextRandom();
					h[k][5:4] = sameSuit ? baseSuit : r[31:30];
					// rank 14 folds back to the ace
					if (runMode) h[k][3:0] = rankT'((runStart + k - 1) % 13 + 1);
					else h[k][3:0] = rankT'(1 + r[23:16] % 13);
				end
				driveHand(h[0], h[1], h[2], h[3], h[4]);
				expectQ.push_back(referenceType(h[0], h[1], h[2], h[3], h[4]));
				textQ.push_back($sformatf("stream hand %0d [%s]", i,
					handText(h[0], h[1], h[2], h[3], h[4])));
			end
		end
	endtask

	// watchdog
	always @(posedge clk) begin
		cycleCount++;
		if (cycleCount >= timeoutCycles) begin
			$display("timeout: run did not finish within %0d cycles", timeoutCycles);
			$display("Some tests failed");
			$finish;
		end
	end

	initial begin
		errorCount = 0;
		lcgState = 32'ha85b;
		arstN = 1'b0;
		driveHand('0, '0, '0, '0, '0);
		testReset();
		testEachType();
		testStraightEdges();
		testPriority();
		testStreaming();
		$display("errors: %0d after %0d cycles", errorCount, cycleCount);
		if (errorCount == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* testbench/tbClock.sv */
`timescale 1ns/10ps
`default_nettype none

// free-running clock, 8 ns period
module tbClock (
	output logic clk
);

	// half of the 8 ns period
	localparam int halfPeriod = 4;

	initial begin
		clk = 1'b0;
		forever #halfPeriod clk = ~clk;
	end

endmodule

`default_nettype wire

/* logic/pokerHand.sv */
`timescale 1ns/10ps
`default_nettype none

// two-stage hand classifier
// stage 1 holds the hand, stage 2 holds the type
// one hand per clock, type out two edges after the hand
module pokerHand (
	input wire logic clk,
	input wire logic arstN,
	input wire cardPkg::cardT card0,
	input wire cardPkg::cardT card1,
	input wire cardPkg::cardT card2,
	input wire cardPkg::cardT card3,
	input wire cardPkg::cardT card4,
	output handPkg::handTypeT handType
);

	import cardPkg::*;
	import handPkg::*;

	// input stage
	cardT heldCard0;
	cardT heldCard1;
	cardT heldCard2;
	cardT heldCard3;
	cardT heldCard4;

	// set once a real hand sits in the input stage
	logic heldValid;

	rankT rank0;
	rankT rank1;
	rankT rank2;
	rankT rank3;
	rankT rank4;
	suitT suit0;
	suitT suit1;
	suitT suit2;
	suitT suit3;
	suitT suit4;

	matchCountT matchCount;
	logic isStraight;
	handTypeT handTypeNext;

	// sample the hand every edge
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			heldCard0 <= '0;
			heldCard1 <= '0;
			heldCard2 <= '0;
			heldCard3 <= '0;
			heldCard4 <= '0;
			heldValid <= 1'b0;
		end else begin
			heldCard0 <= card0;
			heldCard1 <= card1;
			heldCard2 <= card2;
			heldCard3 <= card3;
			heldCard4 <= card4;
			heldValid <= 1'b1;
		end
	end

	// split into rank and suit fields
	assign rank0 = heldCard0[3:0];
	assign rank1 = heldCard1[3:0];
	assign rank2 = heldCard2[3:0];
	assign rank3 = heldCard3[3:0];
	assign rank4 = heldCard4[3:0];
	assign suit0 = heldCard0[5:4];
	assign suit1 = heldCard1[5:4];
	assign suit2 = heldCard2[5:4];
	assign suit3 = heldCard3[5:4];
	assign suit4 = heldCard4[5:4];

	rankMatchCounter uMatch (
		.rank0(rank0),
		.rank1(rank1),
		.rank2(rank2),
		.rank3(rank3),
		.rank4(rank4),
		.matchCount(matchCount)
	);

	straightDetector uStraight (
		.rank0(rank0),
		.rank1(rank1),
		.rank2(rank2),
		.rank3(rank3),
		.rank4(rank4),
		.matchCount(matchCount),
		.isStraight(isStraight)
	);

	handRanker uRanker (
		.suit0(suit0),
		.suit1(suit1),
		.suit2(suit2),
		.suit3(suit3),
		.suit4(suit4),
		.matchCount(matchCount),
		.isStraight(isStraight),
		.handTypeNext(handTypeNext)
	);

	// output stage
	// the cleared hand would read as a flush, so hold highCard until heldValid
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			handType <= highCard;
		end else begin
			handType <= heldValid ? handTypeNext : highCard;
		end
	end

endmodule

`default_nettype wire

/* logic/handRanker.sv */
`timescale 1ns/10ps
`default_nettype none

// flush check and final priority pick
module handRanker (
	input wire cardPkg::suitT suit0,
	input wire cardPkg::suitT suit1,
	input wire cardPkg::suitT suit2,
	input wire cardPkg::suitT suit3,
	input wire cardPkg::suitT suit4,
	input wire handPkg::matchCountT matchCount,
	input wire logic isStraight,
	output handPkg::handTypeT handTypeNext
);

	import handPkg::*;

	logic isFlush;

	// type from rank grouping alone
	handTypeT groupType;

	// all suits equal to the first one
	assign isFlush = (suit0 == suit1) && (suit0 == suit2) &&
		(suit0 == suit3) && (suit0 == suit4);

	// match count to grouping
	always_comb begin
		case (matchCount)
			4'd0: groupType = highCard;
			4'd1: groupType = onePair;
			4'd2: groupType = twoPairs;
			4'd3: groupType = threeOfAKind;
			// trips plus a pair, 3 + 1
			4'd4: groupType = fullHouse;
			// five alike reported as quads
			4'd6, 4'd10: groupType = fourOfAKind;
			// 5, 7, 8, 9 cannot occur with five cards
			default: groupType = highCard;
		endcase
	end

	// flush and straight beat every grouping
	// a straight implies distinct ranks, so no overlap with groups
	always_comb begin
		if (isFlush && isStraight) begin
			handTypeNext = straightFlush;
		end else if (isFlush) begin
			handTypeNext = flush;
		end else if (isStraight) begin
			handTypeNext = straight;
		end else begin
			handTypeNext = groupType;
		end
	end

endmodule

`default_nettype wire

/* logic/straightDetector.sv */
`timescale 1ns/10ps
`default_nettype none

// five consecutive ranks, ace low (A-5) or ace high (10-A)
// no wrap through the ace
module straightDetector (
	input wire cardPkg::rankT rank0,
	input wire cardPkg::rankT rank1,
	input wire cardPkg::rankT rank2,
	input wire cardPkg::rankT rank3,
	input wire cardPkg::rankT rank4,
	input wire handPkg::matchCountT matchCount,
	output logic isStraight
);

	import cardPkg::*;

	rankT ranks [cardsPerHand];
	rankT minRank;
	rankT maxRank;

	// every card is an ace or ten to king
	logic allBroadway;
	// max - min == 4
	logic spanFour;
	logic aceHigh;

	assign ranks[0] = rank0;
	assign ranks[1] = rank1;
	assign ranks[2] = rank2;
	assign ranks[3] = rank3;
	assign ranks[4] = rank4;

	// lowest and highest rank
	always_comb begin
		minRank = ranks[0];
		maxRank = ranks[0];
		for (int i = 1; i < cardsPerHand; i++) begin
			if (ranks[i] < minRank) begin
				minRank = ranks[i];
			end
			if (ranks[i] > maxRank) begin
				maxRank = ranks[i];
			end
		end
	end

	// any card outside {A, 10..K} kills the ace-high case
	always_comb begin
		allBroadway = 1'b1;
		for (int i = 0; i < cardsPerHand; i++) begin
			if (ranks[i] != aceRank && (ranks[i] < tenRank || ranks[i] > kingRank)) begin
				allBroadway = 1'b0;
			end
		end
	end

	// max never below min, 4-bit difference is safe
	assign spanFour = ((maxRank - minRank) == rankT'(4));

	// with distinct ranks, one ace plus four cards in 10..K is exactly 10-J-Q-K-A
	assign aceHigh = (minRank == aceRank) && allBroadway;

	// any repeated rank rules out a straight
	assign isStraight = (matchCount == '0) && (spanFour || aceHigh);

endmodule

`default_nettype wire

/* logic/rankMatchCounter.sv */
`timescale 1ns/10ps
`default_nettype none

// counts how many of the ten rank pairs are equal
// each grouping lands on its own count
//   pair 1, two pairs 2, trips 3, full house 4, quads 6, five alike 10
module rankMatchCounter (
	input wire cardPkg::rankT rank0,
	input wire cardPkg::rankT rank1,
	input wire cardPkg::rankT rank2,
	input wire cardPkg::rankT rank3,
	input wire cardPkg::rankT rank4,
	output handPkg::matchCountT matchCount
);

	import cardPkg::*;
	import handPkg::*;

	// n choose 2 pairs
	localparam int pairCount = cardsPerHand * (cardsPerHand - 1) / 2;

	rankT ranks [cardsPerHand];

	// one flag per pair, ordered 01 02 03 04 12 13 14 23 24 34
	logic [pairCount-1:0] pairEqual;

	// gather ranks for indexed loops
	assign ranks[0] = rank0;
	assign ranks[1] = rank1;
	assign ranks[2] = rank2;
	assign ranks[3] = rank3;
	assign ranks[4] = rank4;

	// pairwise compare
	always_comb begin
		int k;
		k = 0;
		pairEqual = '0;
		for (int i = 0; i < cardsPerHand - 1; i++) begin
			for (int j = i + 1; j < cardsPerHand; j++) begin
				// 4-bit equality per pair
				pairEqual[k] = (ranks[i] == ranks[j]);
				k++;
			end
		end
	end

	// population count of the pair flags
	always_comb begin
		matchCount = '0;
		for (int p = 0; p < pairCount; p++) begin
			matchCount = matchCount + matchCountT'(pairEqual[p]);
		end
	end

endmodule

`default_nettype wire

/* logic/handPkg.sv */
`default_nettype none

package handPkg;

	// reported hand class, 0 to 8
	typedef logic [3:0] handTypeT;

	// number of equal rank pairs out of the ten pairs
	// 0 to 10, so four bits
	typedef logic [3:0] matchCountT;

	// hand codes, weakest first
	localparam handTypeT highCard = 4'd0;
	localparam handTypeT onePair = 4'd1;
	localparam handTypeT twoPairs = 4'd2;
	localparam handTypeT threeOfAKind = 4'd3;
	localparam handTypeT straight = 4'd4;
	localparam handTypeT flush = 4'd5;
	localparam handTypeT fullHouse = 4'd6;
	localparam handTypeT fourOfAKind = 4'd7;
	// best possible hand
	localparam handTypeT straightFlush = 4'd8;

endpackage

`default_nettype wire

/* logic/cardPkg.sv */
`default_nettype none

package cardPkg;

	// one card on six bits
	// suit sits in [5:4], rank in [3:0]
	typedef logic [5:0] cardT;

	// four suits, only equality matters here
	typedef logic [1:0] suitT;

	// rank 1 to 13
	// 0, 14 and 15 are not legal but pass unchecked
	typedef logic [3:0] rankT;

	// five-card game
	localparam int cardsPerHand = 5;

	// ace is encoded low
	localparam rankT aceRank = 4'd1;

	// lowest card of the ace-high run
	localparam rankT tenRank = 4'd10;

	// highest face card
	localparam rankT kingRank = 4'd13;

endpackage

`default_nettype wire
